/* assign_decode.sv */
`timescale 1ns/1ps

module assign_decode import bcp_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  logic      cfg_wr_i,
	input  slot_idx_t cfg_slot_i,
	input  var_id_t   cfg_var_i,
	input  logic      cfg_neg_i,
	input  logic      asg_wr_i,
	input  var_id_t   asg_var_i,
	input  lit_val_e  asg_val_i,
	output slot_cfg_t slot_cfg_o [NUM_LITS],
	output lit_wr_t   lit_wr_o [NUM_LITS]
);

	slot_cfg_t slot_cfg_q [NUM_LITS];
	lit_wr_t   lit_wr_q [NUM_LITS];
	lit_wr_t   lit_wr_d [NUM_LITS];

	// Negation swaps true and false, free and conflict pass unchanged
	function automatic lit_val_e apply_pol(input lit_val_e v, input logic neg);
		lit_val_e r;
		r = v;
		if (neg && v == LV_TRUE)
		begin
			r = LV_FALSE;
		end
		else if (neg && v == LV_FALSE)
		begin
			r = LV_TRUE;
		end
		return r;
	endfunction

	// Next write per slot, configuration has priority
	always_comb
	begin
		for (int i = 0; i < NUM_LITS; i++)
		begin
			lit_wr_d[i].wr  = 1'b0;
			lit_wr_d[i].val = LV_FREE;
			if (cfg_wr_i && cfg_slot_i == slot_idx_t'(i))
			begin
				lit_wr_d[i].wr = 1'b1; // Rebinding frees the literal
			end
			else if (asg_wr_i && slot_cfg_q[i].vid == asg_var_i)
			begin
				lit_wr_d[i].wr  = 1'b1;
				lit_wr_d[i].val = apply_pol(asg_val_i, slot_cfg_q[i].neg);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < NUM_LITS; i++)
			begin
				slot_cfg_q[i] <= '0; // Variable 0, not negated
				lit_wr_q[i]   <= '0;
			end
		end
		else
		begin
			if (cfg_wr_i)
			begin
				slot_cfg_q[cfg_slot_i] <= '{vid: cfg_var_i, neg: cfg_neg_i};
			end
			lit_wr_q <= lit_wr_d;
		end
	end

	assign slot_cfg_o = slot_cfg_q;
	assign lit_wr_o   = lit_wr_q;

endmodule

/* bcp_clause_chk.sv */
`timescale 1ns/1ps

module bcp_clause_chk import bcp_pkg::*;
(
	input logic          clk,
	input logic          rst_i,
	input clause_state_e clause_state_o,
	input logic          imp_o,
	input logic          conflict_o
);

	int fail_cnt = 0; // Number of failed assertions

	a_imp_one: assert property (@(posedge clk) disable iff (rst_i) imp_o |=> !imp_o)
	else
	begin
		$error("imp_o stayed high for more than one cycle");
		fail_cnt++;
	end

	a_cfl_one: assert property (@(posedge clk) disable iff (rst_i) conflict_o |=> !conflict_o)
	else
	begin
		$error("conflict_o stayed high for more than one cycle");
		fail_cnt++;
	end

	a_excl: assert property (@(posedge clk) disable iff (rst_i) !(imp_o && conflict_o))
	else
	begin
		$error("imp_o and conflict_o high together");
		fail_cnt++;
	end

	// Pulses only alongside the matching state
	a_imp_state: assert property (@(posedge clk) disable iff (rst_i)
		imp_o |-> clause_state_o == CS_UNIT)
	else
	begin
		$error("imp_o high outside CS_UNIT");
		fail_cnt++;
	end

	a_cfl_state: assert property (@(posedge clk) disable iff (rst_i)
		conflict_o |-> clause_state_o == CS_CONFLICT)
	else
	begin
		$error("conflict_o high outside CS_CONFLICT");
		fail_cnt++;
	end

	a_reset: assert property (@(posedge clk)
		rst_i |=> (clause_state_o == CS_OPEN && !imp_o && !conflict_o))
	else
	begin
		$error("Outputs active in the cycle after reset");
		fail_cnt++;
	end

endmodule

bind bcp_clause_top bcp_clause_chk u_chk (.*);

/* bcp_clause_top.sv */
`timescale 1ns/1ps

module bcp_clause_top import bcp_pkg::*;
(
	input  logic          clk,
	input  logic          rst_i,
	input  logic          cfg_wr_i,
	input  slot_idx_t     cfg_slot_i,
	input  var_id_t       cfg_var_i,
	input  logic          cfg_neg_i,
	input  logic          asg_wr_i,
	input  var_id_t       asg_var_i,
	input  lit_val_e      asg_val_i,
	output clause_state_e clause_state_o,
	output logic          imp_o,
	output var_id_t       imp_var_o,
	output lit_val_e      imp_val_o,
	output logic          conflict_o
);

	lit_wr_t     lit_wr [NUM_LITS];
	slot_cfg_t   slot_cfg [NUM_LITS];
	clause_res_t res;

	// Slot table and literal writes
	assign_decode u_decode (
		.clk        (clk),
		.rst_i      (rst_i),
		.cfg_wr_i   (cfg_wr_i),
		.cfg_slot_i (cfg_slot_i),
		.cfg_var_i  (cfg_var_i),
		.cfg_neg_i  (cfg_neg_i),
		.asg_wr_i   (asg_wr_i),
		.asg_var_i  (asg_var_i),
		.asg_val_i  (asg_val_i),
		.slot_cfg_o (slot_cfg),
		.lit_wr_o   (lit_wr)
	);

	clause_eval u_eval (
		.clk      (clk),
		.rst_i    (rst_i),
		.lit_wr_i (lit_wr),
		.res_o    (res)
	);

	clause_report u_report (
		.clk            (clk),
		.rst_i          (rst_i),
		.res_i          (res),
		.slot_cfg_i     (slot_cfg),
		.clause_state_o (clause_state_o),
		.imp_o          (imp_o),
		.imp_var_o      (imp_var_o),
		.imp_val_o      (imp_val_o),
		.conflict_o     (conflict_o)
	);

endmodule

/* bcp_pkg.sv */
package bcp_pkg;

	// Clause geometry
	localparam int NUM_LITS = 4;
	localparam int VAR_W    = 6;
	localparam int SLOT_W   = 2;
	localparam int CNT_W    = 2;

	typedef logic [VAR_W-1:0]  var_id_t;
	typedef logic [SLOT_W-1:0] slot_idx_t;
	typedef logic [CNT_W-1:0]  free_cnt_t; // 0, 1, 2 = two or more

	localparam free_cnt_t CNT_SAT = 2'd2; // Saturation point of the free count

	// Value code shared by variables and literals
	typedef enum logic [1:0] {
		LV_FREE     = 2'd0,
		LV_FALSE    = 2'd1,
		LV_TRUE     = 2'd2,
		LV_CONFLICT = 2'd3
	} lit_val_e;

	typedef enum logic [1:0] {
		CS_OPEN     = 2'd0,
		CS_SAT      = 2'd1,
		CS_UNIT     = 2'd2,
		CS_CONFLICT = 2'd3
	} clause_state_e;

	typedef enum logic {
		IDLE = 1'b0,
		HELD = 1'b1
	} rpt_state_e;

	// Binding of one clause slot
	typedef struct packed {
		var_id_t vid;
		logic    neg; // Literal is the negated variable
	} slot_cfg_t;

	// Per-slot write, value in bits [2:1] and strobe in bit 0
	typedef struct packed {
		lit_val_e val;
		logic     wr;
	} lit_wr_t;

	typedef struct packed {
		clause_state_e state;
		slot_idx_t     slot; // Free slot, meaningful for CS_UNIT
	} clause_res_t;

endpackage

/* build.f */
bcp_pkg.sv
lit_cell.sv
assign_decode.sv
clause_eval.sv
clause_report.sv
bcp_clause_top.sv
bcp_clause_chk.sv
tb_bcp_clause.sv

/* clause_eval.sv */
`timescale 1ns/1ps

module clause_eval import bcp_pkg::*;
(
	input  logic        clk,
	input  logic        rst_i,
	input  lit_wr_t     lit_wr_i [NUM_LITS],
	output clause_res_t res_o
);

	free_cnt_t cnt_chain [NUM_LITS+1];
	logic      sat_chain [NUM_LITS+1];
	logic      ff_chain [NUM_LITS+1];
	lit_val_e  lit_val [NUM_LITS];
	logic      cclause [NUM_LITS];
	logic      any_cc;
	slot_idx_t free_slot;

	// Chain head
	assign cnt_chain[0] = '0;
	assign sat_chain[0] = 1'b0;
	assign ff_chain[0]  = 1'b0;

	for (genvar i = 0; i < NUM_LITS; i++)
	begin : g_cell
		lit_cell u_cell (
			.clk               (clk),
			.rst_i             (rst_i),
			.wr_i              (lit_wr_i[i]),
			.freelitcnt_pre_i  (cnt_chain[i]),
			.freelitcnt_next_o (cnt_chain[i+1]),
			.sat_pre_i         (sat_chain[i]),
			.sat_o             (sat_chain[i+1]),
			.first_free_pre_i  (ff_chain[i]),
			.first_free_o      (ff_chain[i+1]),
			.lit_val_o         (lit_val[i]),
			.cclause_o         (cclause[i])
		);
	end

	// First free slot is free with no free slot below it
	always_comb
	begin
		free_slot = '0;
		any_cc    = 1'b0;
		for (int i = 0; i < NUM_LITS; i++)
		begin
			if (lit_val[i] == LV_FREE && !ff_chain[i])
			begin
				free_slot = slot_idx_t'(i);
			end
			any_cc = any_cc | cclause[i];
		end
	end

	always_comb
	begin
		res_o.slot = free_slot;
		if (sat_chain[NUM_LITS])
		begin
			res_o.state = CS_SAT;
		end
		else if (!ff_chain[NUM_LITS] || any_cc) // No free literal left, or a bad code
		begin
			res_o.state = CS_CONFLICT;
		end
		else if (cnt_chain[NUM_LITS] == free_cnt_t'(1))
		begin
			res_o.state = CS_UNIT;
		end
		else
		begin
			res_o.state = CS_OPEN;
		end
	end

endmodule

/* clause_report.sv */
`timescale 1ns/1ps

module clause_report import bcp_pkg::*;
(
	input  logic          clk,
	input  logic          rst_i,
	input  clause_res_t   res_i,
	input  slot_cfg_t     slot_cfg_i [NUM_LITS],
	output clause_state_e clause_state_o,
	output logic          imp_o,
	output var_id_t       imp_var_o,
	output lit_val_e      imp_val_o,
	output logic          conflict_o
);

	clause_state_e state_q;
	rpt_state_e    rpt_q;
	rpt_state_e    rpt_d;
	logic          evt;
	logic          fire;
	logic          imp_q;
	logic          cfl_q;
	var_id_t       imp_var_q;
	lit_val_e      imp_val_q;

	assign evt = (res_i.state == CS_UNIT) || (res_i.state == CS_CONFLICT);

	// HELD while a reported state persists
	always_comb
	begin
		fire  = 1'b0;
		rpt_d = rpt_q;
		case (rpt_q)
			IDLE:
			begin
				fire  = evt;
				rpt_d = evt ? HELD : IDLE;
			end
			HELD:
			begin
				if (res_i.state != state_q)
				begin
					fire  = evt; // Direct move between unit and conflict
					rpt_d = evt ? HELD : IDLE;
				end
			end
			default: rpt_d = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q   <= CS_OPEN;
			rpt_q     <= IDLE;
			imp_q     <= 1'b0;
			cfl_q     <= 1'b0;
			imp_var_q <= '0;
			imp_val_q <= LV_FREE;
		end
		else
		begin
			state_q <= res_i.state;
			rpt_q   <= rpt_d;
			imp_q   <= fire && (res_i.state == CS_UNIT);
			cfl_q   <= fire && (res_i.state == CS_CONFLICT);
			if (fire && res_i.state == CS_UNIT)
			begin
				// Value that makes the free literal true
				imp_var_q <= slot_cfg_i[res_i.slot].vid;
				imp_val_q <= slot_cfg_i[res_i.slot].neg ? LV_FALSE : LV_TRUE;
			end
		end
	end

	assign clause_state_o = state_q;
	assign imp_o          = imp_q;
	assign imp_var_o      = imp_var_q;
	assign imp_val_o      = imp_val_q;
	assign conflict_o     = cfl_q;

endmodule

/* lit_cell.sv */
`timescale 1ns/1ps

module lit_cell import bcp_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  lit_wr_t   wr_i,
	input  free_cnt_t freelitcnt_pre_i,
	output free_cnt_t freelitcnt_next_o,
	input  logic      sat_pre_i,
	output logic      sat_o,
	input  logic      first_free_pre_i,
	output logic      first_free_o,
	output lit_val_e  lit_val_o,
	output logic      cclause_o
);

	lit_val_e lit_q;
	logic     is_free;
	logic     is_true;

	// Literal storage, free after reset
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			lit_q <= LV_FREE;
		end
		else if (wr_i.wr)
		begin
			lit_q <= wr_i.val;
		end
	end

	assign is_free = (lit_q == LV_FREE);
	assign is_true = (lit_q == LV_TRUE);

	// Free count, saturating at two
	always_comb
	begin
		if (is_free && freelitcnt_pre_i != CNT_SAT)
		begin
			freelitcnt_next_o = freelitcnt_pre_i + free_cnt_t'(1);
		end
		else
		begin
			freelitcnt_next_o = freelitcnt_pre_i;
		end
	end

	assign sat_o        = sat_pre_i | is_true;
	assign first_free_o = first_free_pre_i | is_free; // Some slot up to here is free
	assign cclause_o    = (lit_q == LV_CONFLICT);
	assign lit_val_o    = lit_q;

endmodule

/* tb_bcp_clause.sv */
`timescale 1ns/1ps

module tb_bcp_clause import bcp_pkg::*;
();

	localparam int CLK_PERIOD  = 8;
	localparam int NUM_TESTS   = 6;
	localparam int RAND_OPS    = 40;
	localparam int LONGEST_CYC = 3 * (RAND_OPS + NUM_LITS); // Random test takes three cycles per write

	logic          clk = 1'b0;
	logic          rst_i;
	logic          cfg_wr_i;
	slot_idx_t     cfg_slot_i;
	var_id_t       cfg_var_i;
	logic          cfg_neg_i;
	logic          asg_wr_i;
	var_id_t       asg_var_i;
	lit_val_e      asg_val_i;
	clause_state_e clause_state_o;
	logic          imp_o;
	var_id_t       imp_var_o;
	lit_val_e      imp_val_o;
	logic          conflict_o;

	// Reference model of the slot table and the stored literals
	var_id_t       m_var [NUM_LITS];
	logic          m_neg [NUM_LITS];
	lit_val_e      m_lit [NUM_LITS];
	clause_state_e prev_state;

	logic [31:0] seed = 32'h5e27_f133;
	int          errors = 0;
	int          err_at_start;
	int          test_no = 0;
	int          tests_ok = 0;
	int          tests_bad = 0;

	bcp_clause_top bcp_clause_top_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Watchdog allows twice the length of all tests
	initial
	begin
		#(NUM_TESTS * LONGEST_CYC * CLK_PERIOD * 2);
		$display("Timeout: the tests did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic lit_val_e polarity(input lit_val_e v, input logic neg);
		if (!neg || v == LV_FREE || v == LV_CONFLICT)
			return v;
		return (v == LV_TRUE) ? LV_FALSE : LV_TRUE; // Negated literal
	endfunction

	function automatic clause_state_e expected_state();
		int   n_free;
		logic any_true;
		logic any_cfl;
		n_free   = 0;
		any_true = 1'b0;
		any_cfl  = 1'b0;
		foreach (m_lit[i])
		begin
			n_free   += (m_lit[i] == LV_FREE);
			any_true |= (m_lit[i] == LV_TRUE);
			any_cfl  |= (m_lit[i] == LV_CONFLICT);
		end
		if (any_true)
			return CS_SAT;
		if (n_free == 0 || any_cfl)
			return CS_CONFLICT;
		return (n_free == 1) ? CS_UNIT : CS_OPEN;
	endfunction

	function automatic int total_errors();
		return errors + bcp_clause_top_i.u_chk.fail_cnt;
	endfunction

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// Result is visible two cycles after the write cycle
	task automatic settle_and_check();
		clause_state_e exp;
		logic          exp_imp;
		logic          exp_cfl;
		int            slot;
		slot = 0;
		repeat (2) @(negedge clk);
		exp     = expected_state();
		exp_imp = (exp == CS_UNIT) && (prev_state != CS_UNIT);
		exp_cfl = (exp == CS_CONFLICT) && (prev_state != CS_CONFLICT);
		check("clause_state_o", clause_state_o, exp);
		check("imp_o", imp_o, exp_imp);
		check("conflict_o", conflict_o, exp_cfl);
		if (exp_imp)
		begin
			foreach (m_lit[i])
				if (m_lit[i] == LV_FREE)
					slot = i;
			check("imp_var_o", imp_var_o, m_var[slot]);
			check("imp_val_o", imp_val_o, polarity(LV_TRUE, m_neg[slot])); // Makes the literal true
		end
		prev_state = exp;
	endtask

	task automatic cfg_slot(input slot_idx_t s, input var_id_t v, input logic n);
		cfg_wr_i   = 1'b1;
		cfg_slot_i = s;
		cfg_var_i  = v;
		cfg_neg_i  = n;
		@(negedge clk);
		cfg_wr_i = 1'b0;
		m_var[s] = v;
		m_neg[s] = n;
		m_lit[s] = LV_FREE; // Rebinding frees the slot
		settle_and_check();
	endtask

	task automatic assign_var(input var_id_t v, input lit_val_e val);
		asg_wr_i  = 1'b1;
		asg_var_i = v;
		asg_val_i = val;
		@(negedge clk);
		asg_wr_i = 1'b0;
		foreach (m_lit[i])
			if (m_var[i] == v)
				m_lit[i] = polarity(val, m_neg[i]);
		settle_and_check();
	endtask

	task automatic start_test();
		test_no++;
		err_at_start = total_errors();
	endtask

	task automatic end_test(input string name);
		int n;
		n = total_errors() - err_at_start;
		if (n == 0)
			tests_ok++;
		else
			tests_bad++;
		$display("Test %0d (%s) finished with %0d errors", test_no, name, n);
	endtask

	initial
	begin
		logic [31:0] r;
		rst_i      = 1'b1;
		cfg_wr_i   = 1'b0;
		cfg_slot_i = '0;
		cfg_var_i  = '0;
		cfg_neg_i  = 1'b0;
		asg_wr_i   = 1'b0;
		asg_var_i  = '0;
		asg_val_i  = LV_FREE;
		foreach (m_lit[i])
		begin
			m_var[i] = '0;
			m_neg[i] = 1'b0;
			m_lit[i] = LV_FREE;
		end
		prev_state = CS_OPEN;
		repeat (2) @(negedge clk);
		rst_i = 1'b0;

		start_test();
		settle_and_check();
		end_test("reset");

		start_test();
		cfg_slot(0, 1, 1'b0);
		cfg_slot(1, 2, 1'b1);
		cfg_slot(2, 3, 1'b0);
		cfg_slot(3, 4, 1'b1);
		assign_var(1, LV_TRUE);
		assign_var(1, LV_FREE);
		assign_var(2, LV_FALSE); // Negated slot becomes true
		assign_var(2, LV_FREE);
		end_test("satisfaction");

		start_test();
		assign_var(1, LV_FALSE);
		assign_var(2, LV_TRUE);
		assign_var(3, LV_FALSE); // Slot 3 left free
		end_test("unit");

		start_test();
		assign_var(4, LV_TRUE);
		assign_var(4, LV_FREE);
		assign_var(3, LV_CONFLICT);
		assign_var(3, LV_FALSE);
		end_test("conflict");

		start_test();
		cfg_slot(0, 10, 1'b0);
		cfg_slot(1, 10, 1'b1); // Same variable with opposite polarity
		cfg_slot(2, 11, 1'b0);
		cfg_slot(3, 12, 1'b0);
		assign_var(11, LV_FALSE);
		assign_var(12, LV_FALSE);
		assign_var(10, LV_FALSE);
		assign_var(10, LV_TRUE);
		assign_var(10, LV_FALSE);
		cfg_slot(1, 13, 1'b0);
		end_test("shared and reconfigure");

		start_test();
		for (int i = 0; i < NUM_LITS; i++)
		begin
			r = lcg_next();
			cfg_slot(slot_idx_t'(i), var_id_t'(r[22:20]), r[24]);
		end
		repeat (RAND_OPS)
		begin
			r = lcg_next();
			if (r[31:29] == 3'd0)
				cfg_slot(r[17:16], var_id_t'(r[22:20]), r[24]);
			else
				assign_var(var_id_t'(r[22:20]), lit_val_e'(r[26:25]));
		end
		end_test("random");

		$display("Tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad,
			total_errors());
		if (tests_bad == 0 && total_errors() == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
